/* source/rotator_pkg.sv */
// weight rotator package: shared sizes, word and count types, FSM state enums.
`default_nettype none

package rotator_pkg;

  // ######################################################################
  // sizes.
  localparam int WORD_WIDTH       = 32;
  localparam int KH_MAX           = 3;
  localparam int CIN_MAX          = 8;
  localparam int COLS_MAX         = 4;
  localparam int BLOCKS_MAX       = 4;
  localparam int CONFIG_BEATS_KXK = 3;  // k x k kernel.
  localparam int CONFIG_BEATS_1X1 = 2;  // 1 x 1 kernel.
  localparam int BANK_DEPTH       = KH_MAX * CIN_MAX + CONFIG_BEATS_KXK;

  localparam int ADDR_WIDTH   = $clog2(BANK_DEPTH);
  localparam int KH_WIDTH     = $clog2(KH_MAX);
  localparam int CIN_WIDTH    = $clog2(CIN_MAX);
  localparam int COLS_WIDTH   = $clog2(COLS_MAX);
  localparam int BLOCKS_WIDTH = $clog2(BLOCKS_MAX);
  localparam int HDR_WIDTH    = KH_WIDTH + CIN_WIDTH + COLS_WIDTH + BLOCKS_WIDTH;

  // widest of the four count fields.
  localparam int COUNT_WIDTH_A = (KH_WIDTH > CIN_WIDTH) ? KH_WIDTH : CIN_WIDTH;
  localparam int COUNT_WIDTH_B = (COLS_WIDTH > BLOCKS_WIDTH) ? COLS_WIDTH : BLOCKS_WIDTH;
  localparam int COUNT_WIDTH   = (COUNT_WIDTH_A > COUNT_WIDTH_B) ? COUNT_WIDTH_A : COUNT_WIDTH_B;

  // output sideband bits.
  localparam int TUSER_WIDTH           = 4;
  localparam int TUSER_IS_CONFIG       = 0;
  localparam int TUSER_IS_CIN_LAST     = 1;
  localparam int TUSER_IS_TOP_BLOCK    = 2;
  localparam int TUSER_IS_BOTTOM_BLOCK = 3;

  // ######################################################################
  // types.
  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [KH_WIDTH-1:0]     kh_t;      // count minus one.
  typedef logic [CIN_WIDTH-1:0]    cin_t;
  typedef logic [COLS_WIDTH-1:0]   cols_t;
  typedef logic [BLOCKS_WIDTH-1:0] blocks_t;

  typedef enum logic [1:0] {L_IDLE, L_GET_HEADER, L_WRITE, L_COMMIT} load_state_t;
  typedef enum logic [1:0] {R_IDLE, R_PASS_CONFIG, R_READ, R_RELEASE} seq_state_t;

endpackage

`default_nettype wire

/* source/weight_loader.sv */
// weight loader: takes one frame from the input stream and writes it into the free bank.
`default_nettype none

module weight_loader (
  input  wire logic                 i_aclk,
  input  wire logic                 i_reset,
  input  wire logic                 i_s_tvalid,
  input  wire rotator_pkg::word_t   i_s_tdata,
  input  wire logic                 i_s_tlast,
  output logic                      o_s_tready,
  input  wire logic                 i_wr_free,
  output logic                      o_hdr_we,
  output rotator_pkg::kh_t          o_hdr_kh_1,
  output rotator_pkg::cin_t         o_hdr_cin_1,
  output rotator_pkg::cols_t        o_hdr_cols_1,
  output rotator_pkg::blocks_t      o_hdr_blocks_1,
  output logic                      o_wr_en,
  output rotator_pkg::addr_t        o_wr_addr,
  output rotator_pkg::word_t        o_wr_data,
  output logic                      o_commit
);

  rotator_pkg::load_state_t state;
  rotator_pkg::addr_t       wr_addr;
  rotator_pkg::addr_t       last_addr;       // address of the frame's final beat.
  rotator_pkg::addr_t       last_addr_next;
  rotator_pkg::addr_t       cfg_beats;
  logic                     s_handshake;

  // header unpack, kh in the lowest bits.
  assign {o_hdr_blocks_1, o_hdr_cols_1, o_hdr_cin_1, o_hdr_kh_1} =
      i_s_tdata[rotator_pkg::HDR_WIDTH-1:0];

  // config beats plus kh*cin weights, minus one.
  always_comb begin
    cfg_beats = (o_hdr_kh_1 == '0) ? rotator_pkg::addr_t'(rotator_pkg::CONFIG_BEATS_1X1)
                                   : rotator_pkg::addr_t'(rotator_pkg::CONFIG_BEATS_KXK);
    last_addr_next = cfg_beats
                   + (rotator_pkg::addr_t'(o_hdr_kh_1) + rotator_pkg::addr_t'(1))
                   * (rotator_pkg::addr_t'(o_hdr_cin_1) + rotator_pkg::addr_t'(1))
                   - rotator_pkg::addr_t'(1);
  end

  assign o_s_tready  = (state == rotator_pkg::L_GET_HEADER) || (state == rotator_pkg::L_WRITE);
  assign s_handshake = i_s_tvalid && o_s_tready;

  assign o_hdr_we  = (state == rotator_pkg::L_GET_HEADER) && s_handshake;
  assign o_wr_en   = (state == rotator_pkg::L_WRITE) && s_handshake;
  assign o_wr_addr = wr_addr;
  assign o_wr_data = i_s_tdata;
  assign o_commit  = (state == rotator_pkg::L_COMMIT);  // single cycle.

  // ######################################################################
  // write FSM.
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      state   <= rotator_pkg::L_IDLE;
      wr_addr <= '0;
    end else begin
      unique case (state)
        rotator_pkg::L_IDLE: begin
          if (i_wr_free) state <= rotator_pkg::L_GET_HEADER;
        end
        rotator_pkg::L_GET_HEADER: begin
          if (s_handshake) begin
            state   <= rotator_pkg::L_WRITE;
            wr_addr <= '0;
          end
        end
        rotator_pkg::L_WRITE: begin
          if (s_handshake) begin
            wr_addr <= wr_addr + rotator_pkg::addr_t'(1);
            if (i_s_tlast) state <= rotator_pkg::L_COMMIT;
          end
        end
        rotator_pkg::L_COMMIT: state <= rotator_pkg::L_IDLE;
        default: state <= rotator_pkg::L_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (o_hdr_we) last_addr <= last_addr_next;
  end

  // the sender's tlast must agree with the extent given in its own header.
  a_tlast_at_extent: assert property (@(posedge i_aclk) disable iff (i_reset)
    o_wr_en |-> (i_s_tlast == (wr_addr == last_addr)))
    else $error("input tlast does not match header extent");

endmodule

`default_nettype wire

/* source/weight_bank.sv */
// weight bank store: two register-array banks with headers, full flags and ping-pong indices.
`default_nettype none

module weight_bank #(
  parameter int BANK_DEPTH = 32
) (
  input  wire logic                          i_aclk,
  input  wire logic                          i_reset,
  input  wire logic                          i_hdr_we,
  input  wire rotator_pkg::kh_t              i_hdr_kh_1,
  input  wire rotator_pkg::cin_t             i_hdr_cin_1,
  input  wire rotator_pkg::cols_t            i_hdr_cols_1,
  input  wire rotator_pkg::blocks_t          i_hdr_blocks_1,
  input  wire logic                          i_wr_en,
  input  wire logic [$clog2(BANK_DEPTH)-1:0] i_wr_addr,
  input  wire rotator_pkg::word_t            i_wr_data,
  input  wire logic                          i_commit,
  input  wire logic [$clog2(BANK_DEPTH)-1:0] i_rd_addr,
  input  wire logic                          i_release,
  output logic                               o_wr_free,
  output logic                               o_rd_full,
  output rotator_pkg::kh_t                   o_rd_kh_1,
  output rotator_pkg::cin_t                  o_rd_cin_1,
  output rotator_pkg::cols_t                 o_rd_cols_1,
  output rotator_pkg::blocks_t               o_rd_blocks_1,
  output rotator_pkg::word_t                 o_rd_data
);

  rotator_pkg::word_t   mem       [2][BANK_DEPTH];
  rotator_pkg::kh_t     kh_1      [2];
  rotator_pkg::cin_t    cin_1     [2];
  rotator_pkg::cols_t   cols_1    [2];
  rotator_pkg::blocks_t blocks_1  [2];
  logic [1:0]           full;
  logic                 wr_idx;   // bank owned by the loader.
  logic                 rd_idx;   // bank owned by the sequencer.

  always_ff @(posedge i_aclk) begin
    if (i_wr_en) mem[wr_idx][i_wr_addr] <= i_wr_data;
    if (i_hdr_we) begin
      kh_1[wr_idx]     <= i_hdr_kh_1;
      cin_1[wr_idx]    <= i_hdr_cin_1;
      cols_1[wr_idx]   <= i_hdr_cols_1;
      blocks_1[wr_idx] <= i_hdr_blocks_1;
    end
  end

  // ownership hand-off.
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      full   <= '0;
      wr_idx <= 1'b0;
      rd_idx <= 1'b0;
    end else begin
      if (i_commit) begin
        full[wr_idx] <= 1'b1;
        wr_idx       <= ~wr_idx;
      end
      if (i_release) begin
        full[rd_idx] <= 1'b0;
        rd_idx       <= ~rd_idx;
      end
    end
  end

  assign o_wr_free     = ~full[wr_idx];
  assign o_rd_full     = full[rd_idx];
  assign o_rd_kh_1     = kh_1[rd_idx];
  assign o_rd_cin_1    = cin_1[rd_idx];
  assign o_rd_cols_1   = cols_1[rd_idx];
  assign o_rd_blocks_1 = blocks_1[rd_idx];
  assign o_rd_data     = mem[rd_idx][i_rd_addr];  // asynchronous read.

  a_no_write_full: assert property (@(posedge i_aclk) disable iff (i_reset)
    (i_wr_en || i_hdr_we || i_commit) |-> !full[wr_idx])
    else $error("loader wrote into a bank that holds an unread frame");

  a_no_release_empty: assert property (@(posedge i_aclk) disable iff (i_reset)
    i_release |-> full[rd_idx])
    else $error("sequencer released an empty bank");

endmodule

`default_nettype wire

/* source/rotation_sequencer.sv */
// rotation sequencer: sends a bank's config beats once, then replays its weights cols*blocks times.
`default_nettype none

module rotation_sequencer (
  input  wire logic                           i_aclk,
  input  wire logic                           i_reset,
  input  wire logic                           i_rd_full,
  input  wire rotator_pkg::kh_t               i_kh_1,
  input  wire rotator_pkg::cin_t              i_cin_1,
  input  wire rotator_pkg::cols_t             i_cols_1,
  input  wire rotator_pkg::blocks_t           i_blocks_1,
  input  wire rotator_pkg::word_t             i_rd_data,
  input  wire logic                           i_m_tready,
  output rotator_pkg::addr_t                  o_rd_addr,
  output logic                                o_release,
  output logic                                o_m_tvalid,
  output rotator_pkg::word_t                  o_m_tdata,
  output logic                                o_m_tlast,
  output logic [rotator_pkg::TUSER_WIDTH-1:0] o_m_tuser
);

  localparam int CFG_WIDTH = $clog2(rotator_pkg::CONFIG_BEATS_KXK + 1);
  localparam int CW        = rotator_pkg::COUNT_WIDTH;

  // counter levels, innermost first.
  localparam int KH     = 0;
  localparam int CIN    = 1;
  localparam int COLS   = 2;
  localparam int BLOCKS = 3;

  rotator_pkg::seq_state_t state;
  rotator_pkg::addr_t      rd_addr;
  rotator_pkg::addr_t      wt_first;   // first weight address, equals the config count.
  logic [CFG_WIDTH-1:0]    cfg_cnt;
  logic [3:0][CW-1:0]      cnt;
  logic [3:0][CW-1:0]      cnt_max;
  logic [3:0]              cnt_last;
  logic [3:0]              cnt_en;
  logic                    m_handshake;
  logic                    in_read;
  logic                    group_done;

  assign wt_first = (i_kh_1 == '0) ? rotator_pkg::addr_t'(rotator_pkg::CONFIG_BEATS_1X1)
                                   : rotator_pkg::addr_t'(rotator_pkg::CONFIG_BEATS_KXK);

  assign cnt_max[KH]     = CW'(i_kh_1);
  assign cnt_max[CIN]    = CW'(i_cin_1);
  assign cnt_max[COLS]   = CW'(i_cols_1);
  assign cnt_max[BLOCKS] = CW'(i_blocks_1);

  assign in_read     = (state == rotator_pkg::R_READ);
  assign m_handshake = o_m_tvalid && i_m_tready;
  assign group_done  = cnt_last[KH] && cnt_last[CIN];  // one pass over kh*cin.

  // each level steps when every level inside it wraps.
  assign cnt_en[KH]     = in_read && m_handshake;
  assign cnt_en[CIN]    = cnt_en[KH] && cnt_last[KH];
  assign cnt_en[COLS]   = cnt_en[CIN] && cnt_last[CIN];
  assign cnt_en[BLOCKS] = cnt_en[COLS] && cnt_last[COLS];

  // ######################################################################
  // read FSM and nested down-counters.
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      state    <= rotator_pkg::R_IDLE;
      rd_addr  <= '0;
      cfg_cnt  <= '0;
      cnt      <= '0;
      cnt_last <= '0;
    end else begin
      unique case (state)
        rotator_pkg::R_IDLE: begin
          rd_addr <= '0;
          cfg_cnt <= CFG_WIDTH'(wt_first - rotator_pkg::addr_t'(1));
          for (int i = 0; i < 4; i++) begin
            cnt[i]      <= cnt_max[i];
            cnt_last[i] <= (cnt_max[i] == '0);
          end
          if (i_rd_full) state <= rotator_pkg::R_PASS_CONFIG;
        end
        rotator_pkg::R_PASS_CONFIG: begin
          if (m_handshake) begin
            rd_addr <= rd_addr + rotator_pkg::addr_t'(1);  // lands on wt_first.
            if (cfg_cnt == '0) state <= rotator_pkg::R_READ;
            else cfg_cnt <= cfg_cnt - CFG_WIDTH'(1);
          end
        end
        rotator_pkg::R_READ: begin
          if (m_handshake) begin
            rd_addr <= group_done ? wt_first : rd_addr + rotator_pkg::addr_t'(1);
            for (int i = 0; i < 4; i++) begin
              if (cnt_en[i]) begin
                if (cnt_last[i]) begin
                  cnt[i]      <= cnt_max[i];
                  cnt_last[i] <= (cnt_max[i] == '0);
                end else begin
                  cnt[i]      <= cnt[i] - CW'(1);
                  cnt_last[i] <= (cnt[i] == CW'(1));
                end
              end
            end
            if (&cnt_last) state <= rotator_pkg::R_RELEASE;
          end
        end
        rotator_pkg::R_RELEASE: state <= rotator_pkg::R_IDLE;
        default: state <= rotator_pkg::R_IDLE;
      endcase
    end
  end

  assign o_rd_addr = rd_addr;
  assign o_release = (state == rotator_pkg::R_RELEASE);

  // ######################################################################
  // output stream.
  assign o_m_tvalid = (state == rotator_pkg::R_PASS_CONFIG) || in_read;
  assign o_m_tdata  = i_rd_data;
  assign o_m_tlast  = in_read && (&cnt_last);

  assign o_m_tuser[rotator_pkg::TUSER_IS_CONFIG]       = (state == rotator_pkg::R_PASS_CONFIG);
  assign o_m_tuser[rotator_pkg::TUSER_IS_CIN_LAST]     = in_read && group_done;
  assign o_m_tuser[rotator_pkg::TUSER_IS_TOP_BLOCK]    = in_read && (cnt[BLOCKS] == cnt_max[BLOCKS]);
  assign o_m_tuser[rotator_pkg::TUSER_IS_BOTTOM_BLOCK] = in_read && cnt_last[BLOCKS];

  // a stalled beat stays put, data from the bank included.
  a_stall_hold: assert property (@(posedge i_aclk) disable iff (i_reset)
    (o_m_tvalid && !i_m_tready) |=>
      (o_m_tvalid && $stable(o_m_tdata) && $stable(o_m_tlast) && $stable(o_m_tuser)))
    else $error("output beat changed while stalled");

endmodule

`default_nettype wire

/* source/weight_rotator.sv */
// weight rotator top: loader, dual bank store and rotation sequencer between two streams.
`default_nettype none

module weight_rotator (
  input  wire logic                           i_aclk,
  input  wire logic                           i_reset,
  input  wire logic                           i_s_tvalid,
  input  wire rotator_pkg::word_t             i_s_tdata,
  input  wire logic                           i_s_tlast,
  output logic                                o_s_tready,
  input  wire logic                           i_m_tready,
  output logic                                o_m_tvalid,
  output rotator_pkg::word_t                  o_m_tdata,
  output logic                                o_m_tlast,
  output logic [rotator_pkg::TUSER_WIDTH-1:0] o_m_tuser
);

  // write side.
  logic                 hdr_we;
  rotator_pkg::kh_t     hdr_kh_1;
  rotator_pkg::cin_t    hdr_cin_1;
  rotator_pkg::cols_t   hdr_cols_1;
  rotator_pkg::blocks_t hdr_blocks_1;
  logic                 wr_en;
  rotator_pkg::addr_t   wr_addr;
  rotator_pkg::word_t   wr_data;
  logic                 commit;
  logic                 wr_free;

  // read side.
  logic                 rd_full;
  rotator_pkg::kh_t     rd_kh_1;
  rotator_pkg::cin_t    rd_cin_1;
  rotator_pkg::cols_t   rd_cols_1;
  rotator_pkg::blocks_t rd_blocks_1;
  rotator_pkg::addr_t   rd_addr;
  rotator_pkg::word_t   rd_data;
  logic                 release_bank;

  weight_loader u_loader (
    .i_aclk(i_aclk), .i_reset(i_reset),
    .i_s_tvalid(i_s_tvalid), .i_s_tdata(i_s_tdata), .i_s_tlast(i_s_tlast),
    .o_s_tready(o_s_tready), .i_wr_free(wr_free),
    .o_hdr_we(hdr_we), .o_hdr_kh_1(hdr_kh_1), .o_hdr_cin_1(hdr_cin_1),
    .o_hdr_cols_1(hdr_cols_1), .o_hdr_blocks_1(hdr_blocks_1),
    .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_commit(commit)
  );

  weight_bank #(.BANK_DEPTH(rotator_pkg::BANK_DEPTH)) u_bank (
    .i_aclk(i_aclk), .i_reset(i_reset),
    .i_hdr_we(hdr_we), .i_hdr_kh_1(hdr_kh_1), .i_hdr_cin_1(hdr_cin_1),
    .i_hdr_cols_1(hdr_cols_1), .i_hdr_blocks_1(hdr_blocks_1),
    .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data), .i_commit(commit),
    .i_rd_addr(rd_addr), .i_release(release_bank),
    .o_wr_free(wr_free), .o_rd_full(rd_full),
    .o_rd_kh_1(rd_kh_1), .o_rd_cin_1(rd_cin_1), .o_rd_cols_1(rd_cols_1),
    .o_rd_blocks_1(rd_blocks_1), .o_rd_data(rd_data)
  );

  rotation_sequencer u_sequencer (
    .i_aclk(i_aclk), .i_reset(i_reset), .i_rd_full(rd_full),
    .i_kh_1(rd_kh_1), .i_cin_1(rd_cin_1), .i_cols_1(rd_cols_1), .i_blocks_1(rd_blocks_1),
    .i_rd_data(rd_data), .i_m_tready(i_m_tready),
    .o_rd_addr(rd_addr), .o_release(release_bank),
    .o_m_tvalid(o_m_tvalid), .o_m_tdata(o_m_tdata), .o_m_tlast(o_m_tlast),
    .o_m_tuser(o_m_tuser)
  );

endmodule

`default_nettype wire

/* verification/weight_rotator_tb.sv */
// weight rotator testbench: frame stimulus, reference model and assertion checks.
`default_nettype none

module weight_rotator_tb;

  localparam int NUM_FRAMES    = 7;
  localparam int BEAT_TIMEOUT  = 2000;  // cycles per input beat.
  localparam int DRAIN_TIMEOUT = 5000;
  localparam rotator_pkg::word_t CFG_BASE = 32'h0000_8000;  // config words sit above weights.

  logic                                i_aclk;
  logic                                i_reset;
  logic                                i_s_tvalid;
  rotator_pkg::word_t                  i_s_tdata;
  logic                                i_s_tlast;
  logic                                o_s_tready;
  logic                                i_m_tready;
  logic                                o_m_tvalid;
  rotator_pkg::word_t                  o_m_tdata;
  logic                                o_m_tlast;
  logic [rotator_pkg::TUSER_WIDTH-1:0] o_m_tuser;

  // frame shapes as minus-one counts.
  int frame_kh_1     [NUM_FRAMES] = '{2, 0, 2, 0, 1, 0, 2};
  int frame_cin_1    [NUM_FRAMES] = '{3, 7, 7, 0, 2, 4, 1};
  int frame_cols_1   [NUM_FRAMES] = '{1, 3, 0, 0, 2, 0, 3};
  int frame_blocks_1 [NUM_FRAMES] = '{2, 1, 0, 3, 3, 0, 3};

  // descriptors of frames sent so far.
  rotator_pkg::word_t q_tag [$];
  int                 q_kh_1 [$];
  int                 q_cin_1 [$];
  int                 q_cols_1 [$];
  int                 q_blocks_1 [$];

  int                                  frames_in;  // input last beats accepted.
  int                                  out_frame;  // frame now leaving the DUT.
  int                                  out_beat;
  int                                  ready_pct;
  rotator_pkg::word_t                  exp_data;
  logic                                exp_last;
  logic [rotator_pkg::TUSER_WIDTH-1:0] exp_user;
  int                                  data_errs;
  int                                  last_errs;
  int                                  user_errs;
  int                                  proto_errs;
  int                                  timeouts;

  weight_rotator i_weight_rotator (
    .i_aclk(i_aclk), .i_reset(i_reset),
    .i_s_tvalid(i_s_tvalid), .i_s_tdata(i_s_tdata), .i_s_tlast(i_s_tlast),
    .o_s_tready(o_s_tready), .i_m_tready(i_m_tready),
    .o_m_tvalid(o_m_tvalid), .o_m_tdata(o_m_tdata), .o_m_tlast(o_m_tlast),
    .o_m_tuser(o_m_tuser)
  );

  always #2 i_aclk = ~i_aclk;

  always @(negedge i_aclk) begin
    i_m_tready = ($urandom % 100) < ready_pct;  // random back-pressure.
  end

  // ######################################################################
  // reference model.
  always @(negedge i_aclk) begin : model
    int cfg;
    int kc;
    int grp;
    int nblk;
    int n;
    if (out_frame < q_tag.size()) begin
      cfg  = (q_kh_1[out_frame] == 0) ? 2 : 3;
      kc   = (q_kh_1[out_frame] + 1) * (q_cin_1[out_frame] + 1);
      grp  = kc * (q_cols_1[out_frame] + 1);  // one rotation group.
      nblk = q_blocks_1[out_frame] + 1;
      exp_last = (out_beat == cfg + grp * nblk - 1);
      exp_user = '0;
      if (out_beat < cfg) begin
        exp_data = q_tag[out_frame] + CFG_BASE + rotator_pkg::word_t'(out_beat);
        exp_user[rotator_pkg::TUSER_IS_CONFIG] = 1'b1;
      end else begin
        n = out_beat - cfg;
        exp_data = q_tag[out_frame] + rotator_pkg::word_t'(n % kc);
        exp_user[rotator_pkg::TUSER_IS_CIN_LAST]     = ((n % kc) == kc - 1);
        exp_user[rotator_pkg::TUSER_IS_TOP_BLOCK]    = (n < grp);
        exp_user[rotator_pkg::TUSER_IS_BOTTOM_BLOCK] = (n >= grp * (nblk - 1));
      end
    end
  end

  // beat and frame tracking on handshakes.
  always @(posedge i_aclk) begin
    if (i_reset) begin
      frames_in <= 0;
      out_frame <= 0;
      out_beat  <= 0;
    end else begin
      if (i_s_tvalid && o_s_tready && i_s_tlast) frames_in <= frames_in + 1;
      if (o_m_tvalid && i_m_tready) begin
        if (exp_last) begin
          out_beat  <= 0;
          out_frame <= out_frame + 1;
        end else begin
          out_beat <= out_beat + 1;
        end
      end
    end
  end

  // ######################################################################
  // checks.
  a_tdata: assert property (@(posedge i_aclk) disable iff (i_reset)
    (o_m_tvalid && i_m_tready) |-> (o_m_tdata == exp_data))
    else begin
      data_errs++;
      $display("FAIL %0t o_m_tdata got %h expected %h", $time,
               $sampled(o_m_tdata), $sampled(exp_data));
    end

  a_tlast: assert property (@(posedge i_aclk) disable iff (i_reset)
    (o_m_tvalid && i_m_tready) |-> (o_m_tlast == exp_last))
    else begin
      last_errs++;
      $display("FAIL %0t o_m_tlast got %b expected %b", $time,
               $sampled(o_m_tlast), $sampled(exp_last));
    end

  a_tuser: assert property (@(posedge i_aclk) disable iff (i_reset)
    (o_m_tvalid && i_m_tready) |-> (o_m_tuser == exp_user))
    else begin
      user_errs++;
      $display("FAIL %0t o_m_tuser got %b expected %b", $time,
               $sampled(o_m_tuser), $sampled(exp_user));
    end

  a_frame_loaded: assert property (@(posedge i_aclk) disable iff (i_reset)
    o_m_tvalid |-> (out_frame < frames_in))
    else begin
      proto_errs++;
      $display("output beat at %0t with no complete frame loaded", $time);
    end

  a_stall_hold: assert property (@(posedge i_aclk) disable iff (i_reset)
    (o_m_tvalid && !i_m_tready) |=>
      (o_m_tvalid && $stable(o_m_tdata) && $stable(o_m_tlast) && $stable(o_m_tuser)))
    else begin
      proto_errs++;
      $display("output beat changed or dropped while stalled at %0t", $time);
    end

  // two unread frames means both banks are full.
  a_banks_full: assert property (@(posedge i_aclk) disable iff (i_reset)
    (frames_in - out_frame >= 2) |-> !o_s_tready)
    else begin
      proto_errs++;
      $display("input ready at %0t while both banks held unread frames", $time);
    end

  // ######################################################################
  // stimulus.
  function automatic rotator_pkg::word_t pack_header(input int f);
    rotator_pkg::kh_t     kh_1;
    rotator_pkg::cin_t    cin_1;
    rotator_pkg::cols_t   cols_1;
    rotator_pkg::blocks_t blocks_1;
    kh_1     = rotator_pkg::kh_t'(frame_kh_1[f]);
    cin_1    = rotator_pkg::cin_t'(frame_cin_1[f]);
    cols_1   = rotator_pkg::cols_t'(frame_cols_1[f]);
    blocks_1 = rotator_pkg::blocks_t'(frame_blocks_1[f]);
    return rotator_pkg::word_t'({blocks_1, cols_1, cin_1, kh_1});  // kh in the low bits.
  endfunction

  task automatic insert_gap();
    int gap;
    gap = (($urandom % 4) == 0) ? int'($urandom % 3) + 1 : 0;
    if (gap > 0) begin
      i_s_tvalid = 1'b0;
      repeat (gap) @(negedge i_aclk);
    end
  endtask

  // ready only changes on rising edges, so the value seen here holds for the next one.
  task automatic put_beat(input rotator_pkg::word_t data, input logic last);
    int waited;
    waited     = 0;
    i_s_tvalid = 1'b1;
    i_s_tdata  = data;
    i_s_tlast  = last;
    while (!o_s_tready && waited < BEAT_TIMEOUT) begin
      @(negedge i_aclk);
      waited++;
    end
    if (o_s_tready) begin
      @(negedge i_aclk);
    end else begin
      timeouts++;
      i_s_tvalid = 1'b0;
      $display("timeout: input beat not accepted within %0d cycles", BEAT_TIMEOUT);
    end
  endtask

  task automatic send_frame(input int f);
    rotator_pkg::word_t tag;
    int                 cfg;
    int                 kc;
    tag = rotator_pkg::word_t'((f + 1) << 16);
    cfg = (frame_kh_1[f] == 0) ? 2 : 3;
    kc  = (frame_kh_1[f] + 1) * (frame_cin_1[f] + 1);
    q_tag.push_back(tag);
    q_kh_1.push_back(frame_kh_1[f]);
    q_cin_1.push_back(frame_cin_1[f]);
    q_cols_1.push_back(frame_cols_1[f]);
    q_blocks_1.push_back(frame_blocks_1[f]);
    put_beat(pack_header(f), 1'b0);
    for (int j = 0; j < cfg + kc; j++) begin
      if (timeouts == 0) begin
        insert_gap();
        if (j < cfg) put_beat(tag + CFG_BASE + rotator_pkg::word_t'(j), 1'b0);
        else put_beat(tag + rotator_pkg::word_t'(j - cfg), (j == cfg + kc - 1));
      end
    end
    i_s_tvalid = 1'b0;
    i_s_tlast  = 1'b0;
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (out_frame < NUM_FRAMES && waited < DRAIN_TIMEOUT) begin
      @(negedge i_aclk);
      waited++;
    end
    if (out_frame < NUM_FRAMES) begin
      timeouts++;
      $display("timeout: only %0d of %0d frames left the DUT", out_frame, NUM_FRAMES);
    end
  endtask

  initial begin : main
    void'($urandom(32'haa98_dd0f));
    i_aclk     = 1'b0;
    i_reset    = 1'b1;
    i_s_tvalid = 1'b0;
    i_s_tdata  = '0;
    i_s_tlast  = 1'b0;
    i_m_tready = 1'b0;
    ready_pct  = 70;
    repeat (16) @(posedge i_aclk);
    @(negedge i_aclk);
    i_reset = 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      if (timeouts == 0) begin
        if (f == 4) ready_pct = 35;  // slow consumer, both banks fill.
        send_frame(f);
      end
    end
    if (timeouts == 0) wait_for_drain();
    repeat (8) @(negedge i_aclk);  // catch stray beats after the last frame.
    $display("errors: data %0d, last %0d, user %0d, protocol %0d, timeouts %0d",
             data_errs, last_errs, user_errs, proto_errs, timeouts);
    if (data_errs + last_errs + user_errs + proto_errs + timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
source/rotator_pkg.sv
source/weight_loader.sv
source/weight_bank.sv
source/rotation_sequencer.sv
source/weight_rotator.sv
verification/weight_rotator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the weight rotator testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module weight_rotator_tb \
  -f sim.f -o weight_rotator_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/weight_rotator_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "run reported failure"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result line"; exit 1; }
exit 0
